// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = stomp_tb
FILELIST = sim.f
OBJDIR = obj_dir
SIM = $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# the run fails unless the pass message shows up in the output
run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf $(OBJDIR)

// ==== common/stomp_pkg.sv ====
// stomp package
// default sizes, pc and rob entry layouts, stage and flush state encodings
// shared by the front-end flush logic and the rob kill mask
package stomp_pkg;

	// --------------------------------------------------
	// default sizes, the top level may override these
	// --------------------------------------------------
	// execution streams, stream 0 means no stream
	localparam int XSTREAMS = 8;
	localparam int ROB_ENTRIES = 16;
	// keep same-group entries alive as copy targets
	localparam bit SUPPORT_BACKOUT = 1'b1;
	// align, fetch, extract, micro-op, decode, rename
	localparam int NSTAGES = 6;
	// fetch target after reset
	localparam logic [31:0] RSTPC = 32'hFFFC_0000;

	// --------------------------------------------------
	// types
	// --------------------------------------------------
	typedef logic [2:0] stream_t;

	// pc tagged with the stream that fetched it
	typedef struct packed {
		stream_t stream;
		logic [31:0] pc;
	} pc_ext_t;

	// the rob fields the kill logic looks at
	typedef struct packed {
		logic v;
		// sequence number, larger is younger
		logic [7:0] sn;
		stream_t stream;
		// fetch group the entry came in with
		logic [5:0] grp;
		// conditional branch
		logic br;
		// call or jump
		logic cjb;
	} rob_entry_t;

	// one stream fork, parent spawned child
	typedef struct packed {
		logic v;
		stream_t parent;
		stream_t child;
	} dep_write_t;

	// front-end stage order, used as an index into stage arrays
	typedef enum logic [2:0] {
		aln,
		fet,
		ext,
		mot,
		dec,
		ren
	} stage_e;

	// flush in progress tracking
	typedef enum logic {
		idle,
		flushing
	} flush_state_e;

endpackage

// ==== sim.f ====
common/stomp_pkg.sv
stomp/stream_dep_table.sv
stomp/front_stomp.sv
stomp/rob_stomp.sv
stomp/stomp_unit.sv
tb/stomp_tb.sv

// ==== stomp/front_stomp.sv ====
// front-end stomp
// detects the start of a flush, walks the redirect target down the stages
// and keeps each stage stomped until the target shows up there
// also produces the two queue-stage stomps that follow rename
module front_stomp #(
	parameter int XSTREAMS = stomp_pkg::XSTREAMS
) (
	input  logic clk2x,
	input  logic rst,
	input  logic branchmiss,
	input  logic found_destination,
	input  logic advance,
	input  logic advance_seg2,
	input  stomp_pkg::pc_ext_t misspc,
	input  stomp_pkg::pc_ext_t [stomp_pkg::NSTAGES-1:0] stage_pc,
	input  logic [XSTREAMS-1:0] stomped,
	output logic [stomp_pkg::NSTAGES-1:0] stage_stomp,
	output logic stomp_que,
	output logic stomp_quem
);

	localparam int NS = stomp_pkg::NSTAGES;

	logic flush;
	logic flush_q;
	logic flush_start;
	// expected pc per stage, slot i lines up with stage i
	stomp_pkg::pc_ext_t [NS-1:0] tgt;
	// align has no sticky flag, it only sees the flush start
	logic [NS-1:1] sticky;
	logic [NS-1:0] armed;
	// per stage advance, rename moves with the back half
	logic [NS-1:1] adv;
	logic [NS-1:1] clr;
	logic quem_r;

	// --------------------------------------------------
	// flush start
	// --------------------------------------------------
	// branch missed and the target is not already in the rob
	assign flush = branchmiss & ~found_destination;
	// rising edge only, a held miss starts one flush
	assign flush_start = flush & ~flush_q;

	always_ff @(posedge clk2x) begin
		if (rst) begin
			flush_q <= 1'b0;
		end else begin
			flush_q <= flush;
		end
	end

	// --------------------------------------------------
	// redirect target delay line
	// --------------------------------------------------
	always_ff @(posedge clk2x) begin
		if (rst) begin
			for (int i = 0; i < NS; i++) begin
				tgt[i].stream <= 3'd1;
				tgt[i].pc <= stomp_pkg::RSTPC;
			end
		end else begin
			if (flush_start) begin
				tgt[0] <= misspc;
			end
			if (advance | flush_start) begin
				for (int i = 1; i < NS; i++) begin
					tgt[i] <= tgt[i-1];
				end
			end
		end
	end

	// --------------------------------------------------
	// stomp waterfall
	// --------------------------------------------------
	assign armed = {sticky, 1'b0} | {NS{flush_start}};
	// ren is the last stage and takes the seg2 strobe
	assign adv = {advance_seg2, {(NS-2){advance}}};

	always_comb begin
		for (int i = 0; i < NS; i++) begin
			// dependent stream, or wrong pc while the flush is armed
			stage_stomp[i] = stomped[stage_pc[i].stream] |
				(armed[i] & (stage_pc[i].pc != tgt[i].pc));
		end
		for (int i = 1; i < NS; i++) begin
			// target arrived here, or the stage behind is clean
			clr[i] = adv[i] & ((stage_pc[i].pc == tgt[i].pc) | ~stage_stomp[i-1]);
		end
	end

	always_ff @(posedge clk2x) begin
		if (rst) begin
			sticky <= '0;
		end else begin
			for (int i = 1; i < NS; i++) begin
				if (flush_start) begin
					sticky[i] <= 1'b1;
				end else if (clr[i]) begin
					sticky[i] <= 1'b0;
				end
			end
		end
	end

	// --------------------------------------------------
	// queue stomps
	// --------------------------------------------------
	// rename is done by now, these mark entries to drop from the queue
	always_ff @(posedge clk2x) begin
		if (rst) begin
			stomp_que <= 1'b0;
			quem_r <= 1'b0;
		end else begin
			if (advance_seg2 | flush_start) begin
				stomp_que <= stage_stomp[stomp_pkg::ren];
			end
			if (advance_seg2) begin
				quem_r <= stage_stomp[stomp_pkg::dec] | flush;
			end
		end
	end

	assign stomp_quem = flush_start | quem_r;

endmodule

// ==== stomp/rob_stomp.sv ====
// rob stomp
// builds the registered per-entry kill mask for the re-order buffer from
// a resolved branch, plus every entry in a stream that is being stomped
module rob_stomp #(
	parameter int XSTREAMS = stomp_pkg::XSTREAMS,
	parameter int ROB_ENTRIES = stomp_pkg::ROB_ENTRIES,
	parameter bit SUPPORT_BACKOUT = stomp_pkg::SUPPORT_BACKOUT,
	localparam int RW = $clog2(ROB_ENTRIES)
) (
	input  logic clk2x,
	input  logic rst,
	input  logic branch_resolved,
	input  logic branchmiss,
	input  logic found_destination,
	input  logic missid_v,
	input  logic fcu_idv,
	input  logic takb,
	input  logic [RW-1:0] missid,
	input  logic [RW-1:0] destination_rndx,
	input  logic [RW-1:0] fcu_id,
	input  stomp_pkg::stream_t kept_stream,
	input  stomp_pkg::rob_entry_t [ROB_ENTRIES-1:0] rob,
	input  logic [XSTREAMS-1:0] stomped,
	output logic [ROB_ENTRIES-1:0] robentry_stomp
);

	stomp_pkg::rob_entry_t miss_e;
	stomp_pkg::rob_entry_t dest_e;
	stomp_pkg::rob_entry_t fcu_e;
	logic spare_en;
	logic [ROB_ENTRIES-1:0] kill;

	assign miss_e = rob[missid];
	assign dest_e = rob[destination_rndx];
	assign fcu_e = rob[fcu_id];

	// entries after the branch in its own fetch group
	// with backout they stay as copy targets for the register map
	always_comb begin
		if (SUPPORT_BACKOUT) begin
			spare_en = fcu_idv & (fcu_e.br | fcu_e.cjb);
		end else begin
			spare_en = fcu_idv & fcu_e.br & ~takb;
		end
	end

	always_comb begin
		for (int n = 0; n < ROB_ENTRIES; n++) begin
			kill[n] = 1'b0;
			if (branch_resolved) begin
				if (found_destination) begin
					// only the skipped range between branch and target
					kill[n] = (rob[n].sn > miss_e.sn) && (rob[n].sn < dest_e.sn);
				end else begin
					// everything younger that is off the kept stream
					kill[n] = branchmiss && missid_v && (rob[n].sn > miss_e.sn) &&
						(rob[n].stream != kept_stream);
				end
				if (spare_en && (rob[n].grp == fcu_e.grp) && (rob[n].sn > fcu_e.sn)) begin
					kill[n] = 1'b0;
				end
			end
			// dependent streams die regardless of branch state
			if (stomped[rob[n].stream]) begin
				kill[n] = 1'b1;
			end
		end
	end

	// wide fanout into the rat, so registered
	always_ff @(posedge clk2x) begin
		if (rst) begin
			robentry_stomp <= '0;
		end else begin
			robentry_stomp <= kill;
		end
	end

endmodule

// ==== stomp/stomp_unit.sv ====
// stomp unit
// branch-miss flush for the core, front-end stage stomps and rob kill mask
// stream dependencies feed both halves
module stomp_unit #(
	parameter int XSTREAMS = stomp_pkg::XSTREAMS,
	parameter int ROB_ENTRIES = stomp_pkg::ROB_ENTRIES,
	parameter bit SUPPORT_BACKOUT = stomp_pkg::SUPPORT_BACKOUT,
	localparam int RW = $clog2(ROB_ENTRIES)
) (
	input  logic clk2x,
	input  logic rst,
	input  logic branchmiss,
	input  logic found_destination,
	input  logic branch_resolved,
	input  logic missid_v,
	input  logic fcu_idv,
	input  logic takb,
	input  logic advance,
	input  logic advance_seg2,
	input  logic free_v,
	input  stomp_pkg::pc_ext_t misspc,
	input  stomp_pkg::pc_ext_t [stomp_pkg::NSTAGES-1:0] stage_pc,
	input  logic [RW-1:0] missid,
	input  logic [RW-1:0] destination_rndx,
	input  logic [RW-1:0] fcu_id,
	input  stomp_pkg::rob_entry_t [ROB_ENTRIES-1:0] rob,
	input  stomp_pkg::stream_t kept_stream,
	input  stomp_pkg::stream_t free_stream,
	input  stomp_pkg::dep_write_t dep_wr,
	output logic [stomp_pkg::NSTAGES-1:0] stage_stomp,
	output logic stomp_que,
	output logic stomp_quem,
	output logic [ROB_ENTRIES-1:0] robentry_stomp
);

	// streams descended from the kept one
	logic [XSTREAMS-1:0] stomped;

	stream_dep_table #(
		.XSTREAMS(XSTREAMS)
	) u_dep (
		.clk2x(clk2x),
		.rst(rst),
		.dep_wr(dep_wr),
		.free_v(free_v),
		.free_stream(free_stream),
		.kept_stream(kept_stream),
		.stomped(stomped)
	);

	front_stomp #(
		.XSTREAMS(XSTREAMS)
	) u_front (
		.clk2x(clk2x),
		.rst(rst),
		.branchmiss(branchmiss),
		.found_destination(found_destination),
		.advance(advance),
		.advance_seg2(advance_seg2),
		.misspc(misspc),
		.stage_pc(stage_pc),
		.stomped(stomped),
		.stage_stomp(stage_stomp),
		.stomp_que(stomp_que),
		.stomp_quem(stomp_quem)
	);

	rob_stomp #(
		.XSTREAMS(XSTREAMS),
		.ROB_ENTRIES(ROB_ENTRIES),
		.SUPPORT_BACKOUT(SUPPORT_BACKOUT)
	) u_rob (
		.clk2x(clk2x),
		.rst(rst),
		.branch_resolved(branch_resolved),
		.branchmiss(branchmiss),
		.found_destination(found_destination),
		.missid_v(missid_v),
		.fcu_idv(fcu_idv),
		.takb(takb),
		.missid(missid),
		.destination_rndx(destination_rndx),
		.fcu_id(fcu_id),
		.kept_stream(kept_stream),
		.rob(rob),
		.stomped(stomped),
		.robentry_stomp(robentry_stomp)
	);

endmodule

// ==== stomp/stream_dep_table.sv ====
// stream dependency table
// records which streams were forked from which and registers the mask
// of streams that descend from the stream being kept
module stream_dep_table #(
	parameter int XSTREAMS = stomp_pkg::XSTREAMS
) (
	input  logic clk2x,
	input  logic rst,
	input  stomp_pkg::dep_write_t dep_wr,
	input  logic free_v,
	input  stomp_pkg::stream_t free_stream,
	input  stomp_pkg::stream_t kept_stream,
	output logic [XSTREAMS-1:0] stomped
);

	// row = parent, bit = child
	logic [XSTREAMS-1:0] dep [XSTREAMS];
	// descendants of the kept stream, before the register
	logic [XSTREAMS-1:0] desc;

	// row of the kept stream, minus the stream itself
	// stream 0 is not a real stream so nothing descends from it
	always_comb begin
		desc = '0;
		if (kept_stream != '0) begin
			desc = dep[kept_stream];
			desc[kept_stream] = 1'b0;
		end
	end

	always_ff @(posedge clk2x) begin
		if (rst) begin
			for (int r = 0; r < XSTREAMS; r++) begin
				dep[r] <= '0;
			end
			stomped <= '0;
		end else begin
			// a released stream loses its row and its column
			if (free_v) begin
				dep[free_stream] <= '0;
				for (int r = 0; r < XSTREAMS; r++) begin
					dep[r][free_stream] <= 1'b0;
				end
			end
			// fork write after the free, so a same-cycle fork wins
			if (dep_wr.v) begin
				dep[dep_wr.parent][dep_wr.child] <= 1'b1;
			end
			// registered, dependent stomps show up one cycle later
			stomped <= desc;
		end
	end

endmodule

// ==== tb/stomp_tb.sv ====
// stomp unit testbench
// random stimulus from an lfsr, checked each cycle against a reference model
// of the dependency table, target line, sticky flags, queue stomps and rob kill
module stomp_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int XSTREAMS = 8;
	localparam int ROB_ENTRIES = 16;
	localparam bit SUPPORT_BACKOUT = 1'b1;
	localparam int NS = stomp_pkg::NSTAGES;
	localparam int RW = $clog2(ROB_ENTRIES);
	// cycles per test
	localparam int T_RST = 40;
	localparam int T_DEP = 300;
	localparam int T_WF = 400;
	localparam int T_RANGE = 200;
	localparam int T_STREAM = 300;
	localparam int T_HOLD = 8;
	localparam int TOTAL_CYCLES = 16 + T_RST + T_DEP + T_WF + T_RANGE + T_STREAM + T_HOLD + 10;
	// pc well away from the random pool, used by the held-miss test
	localparam logic [31:0] HOLD_PC = 32'h0000_8000;

	logic clk2x;
	logic rst;
	logic branchmiss;
	logic found_destination;
	logic branch_resolved;
	logic missid_v;
	logic fcu_idv;
	logic takb;
	logic advance;
	logic advance_seg2;
	logic free_v;
	stomp_pkg::pc_ext_t misspc;
	stomp_pkg::pc_ext_t [NS-1:0] stage_pc;
	logic [RW-1:0] missid;
	logic [RW-1:0] destination_rndx;
	logic [RW-1:0] fcu_id;
	stomp_pkg::rob_entry_t [ROB_ENTRIES-1:0] rob;
	stomp_pkg::stream_t kept_stream;
	stomp_pkg::stream_t free_stream;
	stomp_pkg::dep_write_t dep_wr;
	logic [NS-1:0] stage_stomp;
	logic stomp_que;
	logic stomp_quem;
	logic [ROB_ENTRIES-1:0] robentry_stomp;

	// reference model state, mirrors the dut registers
	logic [XSTREAMS-1:0] m_dep [XSTREAMS];
	logic [XSTREAMS-1:0] m_stomped;
	logic m_flush_q;
	stomp_pkg::pc_ext_t [NS-1:0] m_tgt;
	logic [NS-1:0] m_sticky;
	logic m_que;
	logic m_quem_r;
	logic [ROB_ENTRIES-1:0] m_kill;

	logic [31:0] lfsr;
	int errors;
	int checks;

	stomp_unit #(
		.XSTREAMS(XSTREAMS),
		.ROB_ENTRIES(ROB_ENTRIES),
		.SUPPORT_BACKOUT(SUPPORT_BACKOUT)
	) stomp_unit_i (
		.clk2x(clk2x),
		.rst(rst),
		.branchmiss(branchmiss),
		.found_destination(found_destination),
		.branch_resolved(branch_resolved),
		.missid_v(missid_v),
		.fcu_idv(fcu_idv),
		.takb(takb),
		.advance(advance),
		.advance_seg2(advance_seg2),
		.free_v(free_v),
		.misspc(misspc),
		.stage_pc(stage_pc),
		.missid(missid),
		.destination_rndx(destination_rndx),
		.fcu_id(fcu_id),
		.rob(rob),
		.kept_stream(kept_stream),
		.free_stream(free_stream),
		.dep_wr(dep_wr),
		.stage_stomp(stage_stomp),
		.stomp_que(stomp_que),
		.stomp_quem(stomp_quem),
		.robentry_stomp(robentry_stomp)
	);

	always #50 clk2x = ~clk2x;

	// --------------------------------------------------
	// random numbers
	// --------------------------------------------------
	// galois lfsr, right shifting, one step per output bit
	function automatic logic lfsr_step();
		logic out;
		out = lfsr[0];
		lfsr = (lfsr >> 1) ^ (out ? 32'hB4BC_D35C : 32'h0);
		return out;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int k = 0; k < n; k++) begin
			r = {r[30:0], lfsr_step()};
		end
		return r;
	endfunction

	// four nearby pcs so that stage and target match often
	function automatic logic [31:0] pick_pc();
		return 32'h0000_1000 | (rand_bits(2) << 4);
	endfunction

	// --------------------------------------------------
	// stimulus helpers, called right after a rising edge
	// --------------------------------------------------
	task automatic quiet_inputs();
		branchmiss <= 1'b0;
		found_destination <= 1'b0;
		branch_resolved <= 1'b0;
		missid_v <= 1'b0;
		fcu_idv <= 1'b0;
		takb <= 1'b0;
		advance <= 1'b0;
		advance_seg2 <= 1'b0;
		free_v <= 1'b0;
		dep_wr.v <= 1'b0;
		kept_stream <= '0;
	endtask

	task automatic drive_stages();
		for (int i = 0; i < NS; i++) begin
			stage_pc[i].stream <= 3'(rand_bits(3));
			stage_pc[i].pc <= pick_pc();
		end
	endtask

	// small grp range so same-group entries show up
	task automatic drive_rob();
		for (int n = 0; n < ROB_ENTRIES; n++) begin
			rob[n].v <= 1'b1;
			rob[n].sn <= 8'(rand_bits(8));
			rob[n].stream <= 3'(rand_bits(3));
			rob[n].grp <= 6'(rand_bits(2));
			rob[n].br <= lfsr_step();
			rob[n].cjb <= lfsr_step();
		end
		missid <= RW'(rand_bits(RW));
		destination_rndx <= RW'(rand_bits(RW));
		fcu_id <= RW'(rand_bits(RW));
	endtask

	// --------------------------------------------------
	// reference model
	// --------------------------------------------------
	task automatic model_reset();
		for (int r = 0; r < XSTREAMS; r++) begin
			m_dep[r] = '0;
		end
		for (int i = 0; i < NS; i++) begin
			m_tgt[i].stream = 3'd1;
			m_tgt[i].pc = stomp_pkg::RSTPC;
		end
		m_stomped = '0;
		m_flush_q = 1'b0;
		m_sticky = '0;
		m_que = 1'b0;
		m_quem_r = 1'b0;
		m_kill = '0;
	endtask

	// dependent stream, or armed stage holding the wrong pc
	function automatic logic [NS-1:0] exp_stage_stomp(input logic fs);
		logic [NS-1:0] s;
		for (int i = 0; i < NS; i++) begin
			s[i] = m_stomped[stage_pc[i].stream] |
				((fs | m_sticky[i]) & (stage_pc[i].pc != m_tgt[i].pc));
		end
		return s;
	endfunction

	function automatic logic [ROB_ENTRIES-1:0] exp_rob_kill();
		stomp_pkg::rob_entry_t me;
		stomp_pkg::rob_entry_t de;
		stomp_pkg::rob_entry_t fe;
		logic spare;
		logic [ROB_ENTRIES-1:0] k;
		me = rob[missid];
		de = rob[destination_rndx];
		fe = rob[fcu_id];
		if (SUPPORT_BACKOUT) begin
			spare = fcu_idv & (fe.br | fe.cjb);
		end else begin
			spare = fcu_idv & fe.br & ~takb;
		end
		for (int n = 0; n < ROB_ENTRIES; n++) begin
			k[n] = 1'b0;
			if (branch_resolved && found_destination) begin
				k[n] = (rob[n].sn > me.sn) && (rob[n].sn < de.sn);
			end
			if (branch_resolved && !found_destination) begin
				k[n] = branchmiss && missid_v && (rob[n].sn > me.sn) &&
					(rob[n].stream != kept_stream);
			end
			if (branch_resolved && spare && rob[n].grp == fe.grp && rob[n].sn > fe.sn) begin
				k[n] = 1'b0;
			end
			if (m_stomped[rob[n].stream]) begin
				k[n] = 1'b1;
			end
		end
		return k;
	endfunction

	task automatic report_mismatch(input string what, input logic [31:0] exp,
		input logic [31:0] got);
		$display("[FAIL] %0d ns: %s is %h, expected %h", $time, what, got, exp);
		errors++;
	endtask

	// inputs are stable at the falling edge, check then step the model
	always @(negedge clk2x) begin : model_check
		logic flush;
		logic fs;
		logic [NS-1:0] es;
		logic [NS-1:0] adv;
		logic [NS-1:0] clr;
		logic [XSTREAMS-1:0] desc;
		logic [ROB_ENTRIES-1:0] kill_next;
		if (rst) begin
			model_reset();
		end else begin
			flush = branchmiss & ~found_destination;
			fs = flush & ~m_flush_q;
			es = exp_stage_stomp(fs);
			checks++;
			assert (stage_stomp === es)
				else report_mismatch("stage_stomp", 32'(es), 32'(stage_stomp));
			assert (stomp_que === m_que)
				else report_mismatch("stomp_que", 32'(m_que), 32'(stomp_que));
			assert (stomp_quem === (fs | m_quem_r))
				else report_mismatch("stomp_quem", 32'(fs | m_quem_r), 32'(stomp_quem));
			assert (robentry_stomp === m_kill)
				else report_mismatch("robentry_stomp", 32'(m_kill), 32'(robentry_stomp));

			// rob mask uses the mask of stomped streams before it updates
			kill_next = exp_rob_kill();
			desc = '0;
			if (kept_stream != '0) begin
				desc = m_dep[kept_stream];
				desc[kept_stream] = 1'b0;
			end
			if (free_v) begin
				m_dep[free_stream] = '0;
				for (int r = 0; r < XSTREAMS; r++) begin
					m_dep[r][free_stream] = 1'b0;
				end
			end
			if (dep_wr.v) begin
				m_dep[dep_wr.parent][dep_wr.child] = 1'b1;
			end
			m_stomped = desc;
			m_kill = kill_next;

			// rename moves on the back half strobe
			adv = {advance_seg2, {(NS-2){advance}}, 1'b0};
			clr = '0;
			for (int i = 1; i < NS; i++) begin
				clr[i] = adv[i] & ((stage_pc[i].pc == m_tgt[i].pc) | ~es[i-1]);
				if (fs) begin
					m_sticky[i] = 1'b1;
				end else if (clr[i]) begin
					m_sticky[i] = 1'b0;
				end
			end
			if (advance_seg2 | fs) begin
				m_que = es[stomp_pkg::ren];
			end
			if (advance_seg2) begin
				m_quem_r = es[stomp_pkg::dec] | flush;
			end
			if (advance | fs) begin
				for (int i = NS - 1; i > 0; i--) begin
					m_tgt[i] = m_tgt[i-1];
				end
			end
			if (fs) begin
				m_tgt[0] = misspc;
			end
			m_flush_q = flush;
		end
	end

	// --------------------------------------------------
	// tests
	// --------------------------------------------------
	task automatic end_test(input int num, input string name, input int errs_before);
		string status;
		if (errors == errs_before) begin
			status = "ok";
		end else begin
			status = "MISMATCH";
		end
		$display("test %0d %s: %s, %0d errors", num, name, status, errors - errs_before);
	endtask

	task automatic run_reset_state();
		int e0;
		e0 = errors;
		repeat (T_RST) begin
			@(posedge clk2x);
			quiet_inputs();
			drive_stages();
			drive_rob();
			@(negedge clk2x);
			assert ({stage_stomp, stomp_que, stomp_quem, robentry_stomp} == '0)
				else report_mismatch("outputs after reset", 32'd0,
					32'({stage_stomp, stomp_que, stomp_quem, robentry_stomp}));
		end
		end_test(1, "reset state", e0);
	endtask

	task automatic run_stream_deps();
		int e0;
		e0 = errors;
		repeat (T_DEP) begin
			@(posedge clk2x);
			quiet_inputs();
			dep_wr.v <= lfsr_step();
			dep_wr.parent <= 3'(rand_bits(3));
			dep_wr.child <= 3'(rand_bits(3));
			free_v <= (rand_bits(2) == 0);
			free_stream <= 3'(rand_bits(3));
			kept_stream <= 3'(rand_bits(3));
			drive_stages();
			drive_rob();
		end
		end_test(2, "stream deps", e0);
	endtask

	task automatic run_waterfall();
		int e0;
		e0 = errors;
		repeat (T_WF) begin
			@(posedge clk2x);
			quiet_inputs();
			branchmiss <= (rand_bits(3) == 0);
			found_destination <= (rand_bits(3) == 0);
			misspc.stream <= 3'(rand_bits(3));
			misspc.pc <= pick_pc();
			advance <= lfsr_step();
			advance_seg2 <= lfsr_step();
			drive_stages();
		end
		end_test(3, "front waterfall", e0);
	endtask

	task automatic run_rob_range();
		int e0;
		e0 = errors;
		repeat (T_RANGE) begin
			@(posedge clk2x);
			quiet_inputs();
			branch_resolved <= 1'b1;
			found_destination <= 1'b1;
			branchmiss <= lfsr_step();
			missid_v <= lfsr_step();
			drive_rob();
		end
		end_test(4, "rob range kill", e0);
	endtask

	task automatic run_rob_stream();
		int e0;
		e0 = errors;
		repeat (T_STREAM) begin
			@(posedge clk2x);
			quiet_inputs();
			branch_resolved <= 1'b1;
			branchmiss <= (rand_bits(2) != 0);
			missid_v <= (rand_bits(2) != 0);
			fcu_idv <= 1'b1;
			takb <= lfsr_step();
			kept_stream <= 3'(rand_bits(3));
			free_v <= lfsr_step();
			free_stream <= 3'(rand_bits(3));
			advance <= lfsr_step();
			advance_seg2 <= lfsr_step();
			drive_stages();
			drive_rob();
		end
		end_test(5, "rob stream kill", e0);
	endtask

	// align only stomps on a flush start, so it counts the starts
	task automatic run_held_miss();
		int e0;
		int starts;
		e0 = errors;
		starts = 0;
		repeat (3) begin
			@(posedge clk2x);
			quiet_inputs();
			for (int i = 0; i < NS; i++) begin
				stage_pc[i].stream <= 3'd0;
				stage_pc[i].pc <= HOLD_PC;
			end
		end
		for (int k = 0; k < T_HOLD; k++) begin
			@(posedge clk2x);
			branchmiss <= 1'b1;
			advance <= 1'b1;
			misspc.stream <= 3'd2;
			misspc.pc <= (k == 0) ? HOLD_PC : pick_pc();
			@(negedge clk2x);
			if (stage_stomp[stomp_pkg::aln]) begin
				starts++;
			end
		end
		@(posedge clk2x);
		quiet_inputs();
		assert (starts == 1)
			else report_mismatch("flush starts while branchmiss held", 32'd1, 32'(starts));
		end_test(6, "held branchmiss", e0);
	endtask

	// --------------------------------------------------
	// main sequence
	// --------------------------------------------------
	initial begin
		clk2x = 1'b0;
		rst = 1'b1;
		lfsr = 32'h8338;
		errors = 0;
		checks = 0;
		branchmiss = 1'b0;
		found_destination = 1'b0;
		branch_resolved = 1'b0;
		missid_v = 1'b0;
		fcu_idv = 1'b0;
		takb = 1'b0;
		advance = 1'b0;
		advance_seg2 = 1'b0;
		free_v = 1'b0;
		misspc = '0;
		stage_pc = '0;
		missid = '0;
		destination_rndx = '0;
		fcu_id = '0;
		rob = '0;
		kept_stream = '0;
		free_stream = '0;
		dep_wr = '0;
		repeat (16) @(posedge clk2x);
		rst <= 1'b0;
		run_reset_state();
		run_stream_deps();
		run_waterfall();
		run_rob_range();
		run_rob_stream();
		run_held_miss();
		repeat (4) @(posedge clk2x);
		$display("summary: 6 tests, %0d cycle checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

	// all tests plus a margin of 100 cycles
	initial begin
		#((TOTAL_CYCLES + 100) * 100);
		$display("watchdog: the tests did not finish in the expected time");
		$display("Regression failed");
		$finish;
	end

endmodule
